// ==== src/usb_ctrl_pkg.sv ====
// shared definitions for the endpoint 0 control logic
// request codes, state enums, descriptor bytes and counter widths
// modules reach these through usb_ctrl_pkg:: scoped names
package usb_ctrl_pkg;

   localparam logic [15:0] VENDOR_ID  = 16'h1209;
   localparam logic [15:0] PRODUCT_ID = 16'h0001;
   localparam logic [7:0]  CTRL_MAX_PACKET = 8'd8;   // bMaxPacketSize0
   localparam int          DEV_DESCR_LEN   = 18;
   localparam int          BC_WIDTH        = 5;      // byte counter, clamped wLength

   typedef logic [BC_WIDTH-1:0] byte_cnt_t;
   typedef logic [6:0]          usb_addr_t;

   typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_DATA, ST_STALL} ctrl_stage_e;

   typedef enum logic [2:0] {
      REQ_NONE,
      REQ_GET_DESCRIPTOR,          // descriptor type not seen yet
      REQ_GET_DESCRIPTOR_DEVICE,
      REQ_GET_CONFIGURATION,
      REQ_SET_ADDRESS,
      REQ_SET_CONFIGURATION,
      REQ_UNSUPPORTED
   } req_e;

   typedef enum logic [1:0] {DEFAULT_STATE, ADDRESS_STATE, CONFIGURED_STATE} dev_state_e;

   // bRequest codes
   typedef enum logic [7:0] {
      STD_REQ_SET_ADDRESS       = 8'h05,
      STD_REQ_GET_DESCRIPTOR    = 8'h06,
      STD_REQ_GET_CONFIGURATION = 8'h08,
      STD_REQ_SET_CONFIGURATION = 8'h09
   } std_req_e;

   // standard device descriptor, index 0 goes out first
   localparam logic [0:DEV_DESCR_LEN-1][7:0] DEV_DESCR = {
      8'h12,                            // bLength
      8'h01,                            // type device
      8'h00, 8'h02,                     // bcdUSB 2.00
      8'h02,                            // CDC device class
      8'h00,                            // subclass at interface level
      8'h00,                            // protocol at interface level
      CTRL_MAX_PACKET,
      VENDOR_ID[7:0], VENDOR_ID[15:8],
      PRODUCT_ID[7:0], PRODUCT_ID[15:8],
      8'h00, 8'h01,                     // bcdDevice 1.00
      8'h00, 8'h00, 8'h00,              // no string indices
      8'h01                             // one configuration
   };

endpackage

// ==== src/setup_if.sv ====
// decoded SETUP packet, from the decoder to the stage machine and device state
// fields hold their value until the next SETUP starts
interface setup_if;

   usb_ctrl_pkg::req_e      req;
   logic                    in_dir;     // bmRequestType direction, 1 = device to host
   logic [7:0]              value_lo;   // wValue low byte
   usb_ctrl_pkg::byte_cnt_t length;     // clamped wLength
   logic                    complete;   // all eight bytes taken

   modport decoder (output req, in_dir, value_lo, length, complete);

   modport stage (input req, in_dir, value_lo, length, complete);

   modport state (input req, value_lo);

endinterface

// ==== src/setup_decoder.sv ====
// takes the eight SETUP bytes from the SIE and classifies the request
// each byte is checked as it arrives, any failed check marks it unsupported
module setup_decoder (
   input  logic                     clk_i,
   input  logic                     rstn,
   input  logic                     usb_reset_i,
   input  logic                     setup_i,
   input  logic [7:0]               out_data_i,
   input  logic                     out_valid_i,
   input  logic                     out_ready_i,
   input  usb_ctrl_pkg::dev_state_e dev_state_i,
   setup_if.decoder                 sif
);

   logic [3:0]         cnt;        // byte index inside the packet
   logic               busy;       // SETUP in progress
   logic               byte_ev;
   usb_ctrl_pkg::req_e req_d;

   assign byte_ev = out_ready_i & out_valid_i & ~setup_i & busy;

   always_comb begin
      req_d = sif.req;
      case (cnt)
         4'd0: begin   // standard request, device recipient
            if (out_data_i[6:0] != 7'd0)
               req_d = usb_ctrl_pkg::REQ_UNSUPPORTED;
            else
               req_d = usb_ctrl_pkg::REQ_NONE;
         end
         4'd1: begin
            if (sif.req == usb_ctrl_pkg::REQ_NONE) begin
               req_d = usb_ctrl_pkg::REQ_UNSUPPORTED;
               case (usb_ctrl_pkg::std_req_e'(out_data_i))
                  usb_ctrl_pkg::STD_REQ_SET_ADDRESS:
                     if (!sif.in_dir)
                        req_d = usb_ctrl_pkg::REQ_SET_ADDRESS;
                  usb_ctrl_pkg::STD_REQ_GET_DESCRIPTOR:
                     if (sif.in_dir)
                        req_d = usb_ctrl_pkg::REQ_GET_DESCRIPTOR;
                  usb_ctrl_pkg::STD_REQ_GET_CONFIGURATION:
                     if (sif.in_dir && dev_state_i != usb_ctrl_pkg::DEFAULT_STATE)
                        req_d = usb_ctrl_pkg::REQ_GET_CONFIGURATION;
                  usb_ctrl_pkg::STD_REQ_SET_CONFIGURATION:
                     if (!sif.in_dir && dev_state_i != usb_ctrl_pkg::DEFAULT_STATE)
                        req_d = usb_ctrl_pkg::REQ_SET_CONFIGURATION;
                  default: ;
               endcase
            end
         end
         4'd2: begin   // wValue low
            if (sif.req == usb_ctrl_pkg::REQ_SET_ADDRESS) begin
               if (out_data_i[7])
                  req_d = usb_ctrl_pkg::REQ_UNSUPPORTED;
            end else if (sif.req == usb_ctrl_pkg::REQ_SET_CONFIGURATION) begin
               if (out_data_i > 8'd1)
                  req_d = usb_ctrl_pkg::REQ_UNSUPPORTED;
            end else if (out_data_i != 8'd0) begin
               req_d = usb_ctrl_pkg::REQ_UNSUPPORTED;
            end
         end
         4'd3: begin   // wValue high, descriptor type
            if (sif.req == usb_ctrl_pkg::REQ_GET_DESCRIPTOR)
               req_d = (out_data_i == 8'd1) ? usb_ctrl_pkg::REQ_GET_DESCRIPTOR_DEVICE
                                            : usb_ctrl_pkg::REQ_UNSUPPORTED;
            else if (out_data_i != 8'd0)
               req_d = usb_ctrl_pkg::REQ_UNSUPPORTED;
         end
         4'd4, 4'd5: begin   // wIndex
            if (out_data_i != 8'd0)
               req_d = usb_ctrl_pkg::REQ_UNSUPPORTED;
         end
         4'd6: begin
            if (sif.req == usb_ctrl_pkg::REQ_GET_CONFIGURATION && out_data_i != 8'd1)
               req_d = usb_ctrl_pkg::REQ_UNSUPPORTED;
            if ((sif.req == usb_ctrl_pkg::REQ_SET_ADDRESS ||
                 sif.req == usb_ctrl_pkg::REQ_SET_CONFIGURATION) && out_data_i != 8'd0)
               req_d = usb_ctrl_pkg::REQ_UNSUPPORTED;
         end
         4'd7: begin   // only descriptor reads may ask for more than 255
            if (out_data_i != 8'd0 && sif.req != usb_ctrl_pkg::REQ_GET_DESCRIPTOR_DEVICE)
               req_d = usb_ctrl_pkg::REQ_UNSUPPORTED;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         cnt          <= 4'd0;
         busy         <= 1'b0;
         sif.complete <= 1'b0;
         sif.req      <= usb_ctrl_pkg::REQ_NONE;
      end else if (usb_reset_i) begin
         cnt          <= 4'd0;
         busy         <= 1'b0;
         sif.complete <= 1'b0;
         sif.req      <= usb_ctrl_pkg::REQ_NONE;
      end else if (out_ready_i && setup_i) begin
         cnt          <= 4'd0;
         busy         <= 1'b1;
         sif.complete <= 1'b0;
         sif.req      <= usb_ctrl_pkg::REQ_NONE;
      end else if (byte_ev) begin
         cnt     <= cnt + 4'd1;
         sif.req <= req_d;
         if (cnt == 4'd7) begin
            busy         <= 1'b0;
            sif.complete <= 1'b1;
         end
      end
   end

   // field payload
   always_ff @(posedge clk_i) begin
      if (byte_ev) begin
         case (cnt)
            4'd0: sif.in_dir   <= out_data_i[7];
            4'd2: sif.value_lo <= out_data_i;
            4'd6: sif.length   <= (out_data_i[7:5] != 3'd0) ? '1 : out_data_i[4:0];
            4'd7: begin
               if (out_data_i != 8'd0)
                  sif.length <= '1;   // saturate
            end
            default: ;
         endcase
      end
   end

   a_cnt_bound : assert property (@(posedge clk_i) disable iff (!rstn)
      busy |-> cnt < 4'd8 && !sif.complete);

endmodule

// ==== src/ctrl_stage_fsm.sv ====
// control transfer stage machine for endpoint 0
// steps through setup, IN data, status and stall on SIE events only
// no-data requests answer the status IN with a ZLP
module ctrl_stage_fsm (
   input  logic                      clk_i,
   input  logic                      rstn,
   input  logic                      usb_reset_i,
   input  logic                      setup_i,
   input  logic                      out_valid_i,
   input  logic                      out_err_i,
   input  logic                      out_ready_i,
   input  logic                      in_data_ack_i,
   input  logic                      in_req_i,
   input  logic                      in_ready_i,
   setup_if.stage                    sif,
   output logic                      in_valid_o,
   output logic                      in_zlp_o,
   output logic                      stall_o,
   output usb_ctrl_pkg::byte_cnt_t   byte_cnt_o,
   output usb_ctrl_pkg::req_e        req_o,
   output logic                      status_done_o
);

   usb_ctrl_pkg::ctrl_stage_e stage_q;
   usb_ctrl_pkg::byte_cnt_t   cnt_q;
   usb_ctrl_pkg::byte_cnt_t   limit;
   logic                      in_req_q;
   logic                      data_in;   // IN data stage, else ZLP status
   logic                      out_end;
   logic                      ack_ev;

   assign data_in = sif.in_dir & (sif.length != '0);
   assign out_end = out_ready_i & ~setup_i & ~out_err_i & ~out_valid_i & ~in_data_ack_i;
   assign ack_ev  = out_ready_i & ~setup_i & ~out_err_i & in_data_ack_i;

   always_comb begin
      if (sif.req == usb_ctrl_pkg::REQ_GET_CONFIGURATION)
         limit = usb_ctrl_pkg::byte_cnt_t'(1);
      else if (sif.length > usb_ctrl_pkg::byte_cnt_t'(usb_ctrl_pkg::DEV_DESCR_LEN))
         limit = usb_ctrl_pkg::byte_cnt_t'(usb_ctrl_pkg::DEV_DESCR_LEN);
      else
         limit = sif.length;
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         stage_q  <= usb_ctrl_pkg::ST_IDLE;
         cnt_q    <= '0;
         in_req_q <= 1'b0;
      end else begin
         in_req_q <= in_req_i;
         if (usb_reset_i) begin
            stage_q <= usb_ctrl_pkg::ST_IDLE;
            cnt_q   <= '0;
         end else if (out_ready_i && out_err_i) begin
            if (stage_q != usb_ctrl_pkg::ST_STALL)
               stage_q <= usb_ctrl_pkg::ST_IDLE;   // aborted, host retries
         end else if (out_ready_i && setup_i) begin
            stage_q <= usb_ctrl_pkg::ST_SETUP;
            cnt_q   <= '0;
         end else begin
            case (stage_q)
               usb_ctrl_pkg::ST_SETUP: begin
                  if (out_end) begin
                     if (!sif.complete || sif.req == usb_ctrl_pkg::REQ_UNSUPPORTED)
                        stage_q <= usb_ctrl_pkg::ST_STALL;
                     else
                        stage_q <= usb_ctrl_pkg::ST_DATA;
                  end else if (out_ready_i && out_valid_i && sif.complete) begin
                     stage_q <= usb_ctrl_pkg::ST_STALL;   // ninth byte
                  end
               end
               usb_ctrl_pkg::ST_DATA: begin
                  if (out_ready_i && out_valid_i)
                     stage_q <= usb_ctrl_pkg::ST_STALL;   // no OUT data stage here
                  else if (data_in && in_ready_i && cnt_q < limit)
                     cnt_q <= cnt_q + 1'b1;
                  else if (status_done_o)
                     stage_q <= usb_ctrl_pkg::ST_IDLE;
               end
               default: ;
            endcase
         end
      end
   end

   // OUT ZLP ends a read, ACK of our ZLP ends a no-data request
   assign status_done_o = (stage_q == usb_ctrl_pkg::ST_DATA) & ~usb_reset_i &
                          (data_in ? out_end : ack_ev);

   assign in_valid_o = in_req_q & (stage_q == usb_ctrl_pkg::ST_DATA) &
                       (!data_in || cnt_q < limit);
   assign in_zlp_o   = in_req_q & (stage_q == usb_ctrl_pkg::ST_DATA) & ~data_in;
   assign stall_o    = (stage_q == usb_ctrl_pkg::ST_STALL);
   assign byte_cnt_o = cnt_q;
   assign req_o      = (stage_q == usb_ctrl_pkg::ST_DATA && data_in) ? sif.req
                                                                     : usb_ctrl_pkg::REQ_NONE;

   // a ZLP only ever answers a complete, accepted SETUP
   a_zlp_valid : assert property (@(posedge clk_i) disable iff (!rstn)
      in_zlp_o |-> in_valid_o && sif.complete && sif.req != usb_ctrl_pkg::REQ_UNSUPPORTED);

endmodule

// ==== src/dev_state_reg.sv ====
// device state and address of the function
// SET_ADDRESS and SET_CONFIGURATION only take effect once their status
// stage is ACKed, one clock after status_done_i
module dev_state_reg (
   input  logic                      clk_i,
   input  logic                      rstn,
   input  logic                      usb_reset_i,
   input  logic                      status_done_i,
   setup_if.state                    sif,
   output usb_ctrl_pkg::dev_state_e  dev_state_o,
   output usb_ctrl_pkg::usb_addr_t   addr_o
);

   usb_ctrl_pkg::usb_addr_t pend_addr;
   logic                    pend_cfg;

   // follows wValue while the request is decoded
   always_ff @(posedge clk_i) begin
      if (sif.req == usb_ctrl_pkg::REQ_SET_ADDRESS)
         pend_addr <= sif.value_lo[6:0];
      if (sif.req == usb_ctrl_pkg::REQ_SET_CONFIGURATION)
         pend_cfg <= sif.value_lo[0];
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         dev_state_o <= usb_ctrl_pkg::DEFAULT_STATE;
         addr_o      <= '0;
      end else if (usb_reset_i) begin
         dev_state_o <= usb_ctrl_pkg::DEFAULT_STATE;
         addr_o      <= '0;
      end else if (status_done_i) begin
         case (sif.req)
            usb_ctrl_pkg::REQ_SET_ADDRESS: begin
               addr_o      <= pend_addr;
               dev_state_o <= (pend_addr == '0) ? usb_ctrl_pkg::DEFAULT_STATE
                                                : usb_ctrl_pkg::ADDRESS_STATE;
            end
            usb_ctrl_pkg::REQ_SET_CONFIGURATION:
               dev_state_o <= pend_cfg ? usb_ctrl_pkg::CONFIGURED_STATE
                                       : usb_ctrl_pkg::ADDRESS_STATE;
            default: ;
         endcase
      end
   end

   a_default_addr : assert property (@(posedge clk_i) disable iff (!rstn)
      dev_state_o == usb_ctrl_pkg::DEFAULT_STATE |-> addr_o == '0);

endmodule

// ==== src/in_data_mux.sv ====
// picks the IN byte for the active data request
// device descriptor by byte index, or the current configuration value
module in_data_mux (
   input  usb_ctrl_pkg::req_e        req_i,
   input  usb_ctrl_pkg::byte_cnt_t   byte_cnt_i,
   input  usb_ctrl_pkg::dev_state_e  dev_state_i,
   output logic [7:0]                in_data_o
);

   logic desc_hit;   // index inside the descriptor

   assign desc_hit = byte_cnt_i < usb_ctrl_pkg::byte_cnt_t'(usb_ctrl_pkg::DEV_DESCR_LEN);

   always_comb begin
      in_data_o = 8'd0;
      case (req_i)
         usb_ctrl_pkg::REQ_GET_DESCRIPTOR_DEVICE: begin
            if (desc_hit)
               in_data_o = usb_ctrl_pkg::DEV_DESCR[byte_cnt_i];
         end
         usb_ctrl_pkg::REQ_GET_CONFIGURATION: begin
            // only configuration value 1 exists
            if (dev_state_i == usb_ctrl_pkg::CONFIGURED_STATE)
               in_data_o = 8'd1;
         end
         default: ;   // no data request
      endcase
   end

endmodule

// ==== src/ctrl_endp.sv ====
// endpoint 0 control logic behind a full-speed SIE
// decodes SETUP, runs the control stages and keeps address and state
module ctrl_endp (
   input  logic                    clk_i,
   input  logic                    rstn,
   input  logic                    usb_reset_i,
   input  logic                    setup_i,
   input  logic [7:0]              out_data_i,
   input  logic                    out_valid_i,
   input  logic                    out_err_i,
   input  logic                    out_ready_i,
   input  logic                    in_data_ack_i,
   input  logic                    in_req_i,
   input  logic                    in_ready_i,
   output logic [7:0]              in_data_o,
   output logic                    in_valid_o,
   output logic                    in_zlp_o,
   output logic                    stall_o,
   output usb_ctrl_pkg::usb_addr_t addr_o,
   output logic                    configured_o
);

   setup_if                  sif ();
   usb_ctrl_pkg::dev_state_e dev_state;
   usb_ctrl_pkg::byte_cnt_t  byte_cnt;
   usb_ctrl_pkg::req_e       data_req;
   logic                     status_done;

   assign configured_o = (dev_state == usb_ctrl_pkg::CONFIGURED_STATE);

   setup_decoder u_dec (.clk_i, .rstn, .usb_reset_i, .setup_i, .out_data_i, .out_valid_i,
                        .out_ready_i, .dev_state_i(dev_state), .sif(sif));

   ctrl_stage_fsm u_fsm (.clk_i, .rstn, .usb_reset_i, .setup_i, .out_valid_i, .out_err_i,
                         .out_ready_i, .in_data_ack_i, .in_req_i, .in_ready_i, .sif(sif),
                         .in_valid_o, .in_zlp_o, .stall_o, .byte_cnt_o(byte_cnt),
                         .req_o(data_req), .status_done_o(status_done));

   dev_state_reg u_state (.clk_i, .rstn, .usb_reset_i, .status_done_i(status_done),
                          .sif(sif), .dev_state_o(dev_state), .addr_o);

   in_data_mux u_mux (.req_i(data_req), .byte_cnt_i(byte_cnt), .dev_state_i(dev_state),
                      .in_data_o);

endmodule

// ==== bench/host_tasks.svh ====
// SIE side of the endpoint 0 testbench
// token, packet and handshake tasks plus the reference model functions
// included inside tb_ctrl_endp, the tasks drive its signals directly

// device descriptor as the USB spec lays it out
function automatic logic [7:0] descr_byte(int idx);
   logic [7:0] b;
   case (idx)
      0:       b = 8'd18;   // bLength
      1:       b = 8'h01;   // device
      3:       b = 8'h02;   // USB 2.00
      4:       b = 8'h02;   // CDC class
      7:       b = usb_ctrl_pkg::CTRL_MAX_PACKET;
      8:       b = usb_ctrl_pkg::VENDOR_ID[7:0];
      9:       b = usb_ctrl_pkg::VENDOR_ID[15:8];
      10:      b = usb_ctrl_pkg::PRODUCT_ID[7:0];
      11:      b = usb_ctrl_pkg::PRODUCT_ID[15:8];
      13:      b = 8'h01;   // bcdDevice 1.00
      17:      b = 8'h01;   // one configuration
      default: b = 8'h00;
   endcase
   return b;
endfunction

function automatic logic [7:0] expected_in_byte(int kind, int idx, int st);
   if (kind == KIND_DESCR)
      return descr_byte(idx);
   return (st == S_CONFIGURED) ? 8'd1 : 8'd0;
endfunction

// a device never sends more than it has
function automatic int expected_count(int len);
   return (len < 18) ? len : 18;
endfunction

function automatic int state_after(int st, logic [7:0] breq, int val);
   if (breq == 8'h05)
      return (val == 0) ? S_DEFAULT : S_ADDRESS;
   if (breq == 8'h09 && st != S_DEFAULT)
      return (val == 1) ? S_CONFIGURED : S_ADDRESS;
   return st;   // refused or read only
endfunction

task automatic check_eq(string what, int got, int exp);
   assert (got == exp) else begin
      $display("CHECK FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
      err_cnt++;
   end
endtask

// one out_ready_i event, one clock long, entered on a falling edge
task automatic sie_event(logic setup, logic valid, logic ack, logic [7:0] data);
   setup_i       = setup;
   out_valid_i   = valid;
   in_data_ack_i = ack;
   out_data_i    = data;
   out_ready_i   = 1'b1;
   @(negedge clk_i);
   out_ready_i   = 1'b0;
   setup_i       = 1'b0;
   out_valid_i   = 1'b0;
   in_data_ack_i = 1'b0;
endtask

task automatic send_setup(logic [7:0] bm, logic [7:0] breq, logic [15:0] wvalue,
                          logic [15:0] wlen);
   logic [63:0] pkt;
   pkt = {wlen, 16'h0000, wvalue, breq, bm};   // byte 0 in the low bits
   sie_event(1'b1, 1'b0, 1'b0, 8'h00);
   check_eq("stall low after SETUP token", int'(stall_o), 0);
   for (int i = 0; i < 8; i++)
      sie_event(1'b0, 1'b1, 1'b0, pkt[8*i +: 8]);
   sie_event(1'b0, 1'b0, 1'b0, 8'h00);   // end of the SETUP transaction
endtask

// one IN packet, up to the max packet size, returns the byte count
task automatic read_packet(output int n);
   n = 0;
   in_req_i = 1'b1;
   @(negedge clk_i);
   while (n < PKT && in_valid_o) begin
      in_ready_i = 1'b1;
      @(negedge clk_i);
      n++;
   end
   in_ready_i = 1'b0;
   in_req_i   = 1'b0;
endtask

task automatic in_transfer(logic [7:0] breq, logic [15:0] wvalue, logic [15:0] wlen, int kind);
   int n;
   exp_kind = kind;
   rx_base  = rx_total;
   send_setup(8'h80, breq, wvalue, wlen);
   do begin
      read_packet(n);
      sie_event(1'b0, 1'b0, 1'b1, 8'h00);   // host ACK
   end while (n == PKT && rx_total - rx_base < int'(wlen));
   sie_event(1'b0, 1'b0, 1'b0, 8'h00);      // OUT ZLP status
endtask

task automatic nodata_transfer(logic [7:0] breq, logic [15:0] wvalue);
   send_setup(8'h00, breq, wvalue, 16'h0000);
   in_req_i = 1'b1;
   @(negedge clk_i);
   check_eq("status ZLP offered", int'(in_valid_o & in_zlp_o), 1);
   in_ready_i = 1'b1;
   @(negedge clk_i);
   in_ready_i = 1'b0;
   in_req_i   = 1'b0;
   // nothing may change before the host ACKs
   check_eq("addr before status ACK", int'(addr_o), model_addr);
   check_eq("configured before status ACK", int'(configured_o), int'(model_state == S_CONFIGURED));
   sie_event(1'b0, 1'b0, 1'b1, 8'h00);
endtask

task automatic stalled_setup(logic [7:0] bm, logic [7:0] breq, logic [15:0] wvalue);
   send_setup(bm, breq, wvalue, 16'h0000);
   check_eq("stall after unsupported SETUP", int'(stall_o), 1);
endtask

task automatic desc_read(logic [15:0] len);
   in_transfer(8'h06, 16'h0100, len, KIND_DESCR);
   check_eq("descriptor byte count", rx_total - rx_base, expected_count(int'(len)));
endtask

task automatic config_read();
   in_transfer(8'h08, 16'h0000, 16'h0001, KIND_CONFIG);
   check_eq("configuration byte count", rx_total - rx_base, 1);
endtask

// ==== bench/tb_ctrl_endp.sv ====
// testbench for the endpoint 0 control logic
// plays the SIE side of standard control transfers against dut0 and
// checks IN bytes, address and configuration against a small model
module tb_ctrl_endp;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int PKT          = int'(usb_ctrl_pkg::CTRL_MAX_PACKET);
   localparam int S_DEFAULT    = 0;
   localparam int S_ADDRESS    = 1;
   localparam int S_CONFIGURED = 2;
   localparam int KIND_DESCR   = 0;
   localparam int KIND_CONFIG  = 1;
   localparam int MAX_CYCLES   = 20 * 60 * 3 + 400;   // ~20 transfers of <=60 cycles, x3

   logic clk_i, rstn, usb_reset_i, setup_i, out_valid_i, out_err_i, out_ready_i;
   logic in_data_ack_i, in_req_i, in_ready_i;
   logic [7:0] out_data_i, in_data_o;
   logic in_valid_o, in_zlp_o, stall_o, configured_o;
   usb_ctrl_pkg::usb_addr_t addr_o;

   int seed = 73791;
   int err_cnt = 0, cmp_err = 0, rx_total = 0, rx_base = 0, exp_kind = 0, cycles = 0;
   int model_state = 0, model_addr = 0, test_no = 0, test_err = 0, r;
   logic [15:0] wlen;
   logic [6:0]  new_addr;

   `include "host_tasks.svh"

   ctrl_endp dut0 (.*);

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: tests did not finish within %0d clock cycles", MAX_CYCLES);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // every byte the SIE consumes is held against the reference
   always @(posedge clk_i) begin
      if (rstn && in_ready_i && in_valid_o && !in_zlp_o) begin
         assert (in_data_o == expected_in_byte(exp_kind, rx_total - rx_base, model_state))
         else begin
            $display("CHECK FAILED at %0t ns: IN byte %0d is %02h, expected %02h", $time,
                     rx_total - rx_base, in_data_o,
                     expected_in_byte(exp_kind, rx_total - rx_base, model_state));
            cmp_err++;
         end
         rx_total++;
      end
   end

   task automatic finish_test(string name);
      int n;
      n = err_cnt + cmp_err - test_err;
      test_no++;
      $display("test %0d %s: %s, %0d errors", test_no, name, (n == 0) ? "ok" : "bad", n);
      test_err = err_cnt + cmp_err;
   endtask

   initial begin
      rstn = 1'b0;
      usb_reset_i = 1'b0;
      setup_i = 1'b0;
      out_data_i = 8'h00;
      out_valid_i = 1'b0;
      out_err_i = 1'b0;
      out_ready_i = 1'b0;
      in_data_ack_i = 1'b0;
      in_req_i = 1'b0;
      in_ready_i = 1'b0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rstn = 1'b1;

      check_eq("addr after reset", int'(addr_o), 0);
      check_eq("configured after reset", int'(configured_o), 0);
      check_eq("stall after reset", int'(stall_o), 0);
      check_eq("in_valid after reset", int'(in_valid_o | in_zlp_o), 0);
      finish_test("reset values");

      for (int i = 0; i < 6; i++) begin
         r = $random(seed);
         wlen = 16'((r & 32'h7fff_ffff) % 31 + 1);
         desc_read(wlen);
      end
      finish_test("get device descriptor");

      r = $random(seed);
      new_addr = 7'((r & 32'h7fff_ffff) % 127 + 1);
      nodata_transfer(8'h05, {9'd0, new_addr});
      model_state = state_after(model_state, 8'h05, int'(new_addr));
      model_addr = int'(new_addr);
      check_eq("addr after status ACK", int'(addr_o), model_addr);
      finish_test("set address");

      nodata_transfer(8'h09, 16'h0001);
      model_state = state_after(model_state, 8'h09, 1);
      check_eq("configured after set 1", int'(configured_o), 1);
      config_read();
      nodata_transfer(8'h09, 16'h0000);
      model_state = state_after(model_state, 8'h09, 0);
      check_eq("configured after set 0", int'(configured_o), 0);
      config_read();
      finish_test("set and get configuration");

      stalled_setup(8'h00, 8'h03, 16'h0001);   // SET_FEATURE is not kept
      desc_read(16'd18);
      stalled_setup(8'h21, 8'h09, 16'h0001);   // class request
      config_read();
      finish_test("stall on unsupported");

      nodata_transfer(8'h09, 16'h0001);
      model_state = state_after(model_state, 8'h09, 1);
      usb_reset_i = 1'b1;
      @(negedge clk_i);
      usb_reset_i = 1'b0;
      model_state = S_DEFAULT;
      model_addr = 0;
      check_eq("addr after bus reset", int'(addr_o), 0);
      check_eq("configured after bus reset", int'(configured_o), 0);
      stalled_setup(8'h00, 8'h09, 16'h0001);   // refused in default state
      sie_event(1'b0, 1'b0, 1'b1, 8'h00);      // status ACK must not commit it
      check_eq("configured after refused set", int'(configured_o), 0);
      desc_read(16'd8);
      finish_test("bus reset");

      $display("tests run: %0d, errors: %0d", test_no, err_cnt + cmp_err);
      if (err_cnt + cmp_err == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== ctrl_endp.f ====
src/usb_ctrl_pkg.sv
src/setup_if.sv
src/setup_decoder.sv
src/ctrl_stage_fsm.sv
src/dev_state_reg.sv
src/in_data_mux.sv
src/ctrl_endp.sv
+incdir+bench
bench/tb_ctrl_endp.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the endpoint 0 testbench with Verilator and runs it
# the exit status is non-zero unless the log holds the pass line
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_ctrl_endp -f ctrl_endp.f -o sim_ctrl_endp
./obj_dir/sim_ctrl_endp | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
   echo "run_sim: pass"
else
   echo "run_sim: fail, see sim.log"
   exit 1
fi
